// ==== hw/armPkg.sv ====
//------------------------------
// ARM subset package
// Shared word types and ISA encodings
//------------------------------
package armPkg;

   typedef logic [31:0] word_t;     // Data word or byte address
   typedef logic [3:0]  regAddr_t;

   // Status flags in CPSR order
   typedef struct packed {
      logic n;
      logic z;
      logic c;
      logic v;
   } flags_t;

   localparam regAddr_t PcReg      = 4'd15;
   localparam word_t    InstrBytes = 32'd4;

   // Condition 1111 never executes, so this word is a pipeline bubble
   localparam word_t    NopInstr   = 32'hF000_0000;

   // Instruction bits 27:26
   typedef enum logic [1:0] {
      opDataProc = 2'b00,
      opMemory   = 2'b01,
      opBranch   = 2'b10
   } opClass_e;

   // Data-processing funct, bits 24:21
   typedef enum logic [3:0] {
      dpAnd = 4'b0000,
      dpEor = 4'b0001,
      dpSub = 4'b0010,
      dpAdd = 4'b0100,
      dpCmp = 4'b1010,
      dpOrr = 4'b1100,
      dpMov = 4'b1101
   } dpFunct_e;

   typedef enum logic [2:0] {
      aluAdd,
      aluSub,
      aluAnd,
      aluOrr,
      aluEor,
      aluPassB    // MOV
   } aluOp_e;

   typedef enum logic [3:0] {
      condEq, condNe, condCs, condCc, condMi, condPl, condVs, condVc,
      condHi, condLs, condGe, condLt, condGt, condLe, condAl
   } condCode_e;

   typedef enum logic [1:0] {
      imm8,       // Data-processing immediate, zero extended
      imm12,      // LDR/STR offset
      branch24    // Signed word offset
   } immSrc_e;

   typedef enum logic [1:0] {
      fromReg       = 2'b00,
      fromWriteback = 2'b01,
      fromMemory    = 2'b10
   } forwardSel_e;

endpackage

// ==== hw/alu.sv ====
//------------------------------
// ALU
// Add, sub, logic ops and NZCV
//------------------------------
module alu import armPkg::*; (
   input  word_t  a,
   input  word_t  b,
   input  aluOp_e aluOp,
   output word_t  result,
   output flags_t flags
);

   logic        subtract;
   logic        arith;
   word_t       bEff;
   logic [32:0] sum;
   logic        overflow;

   assign subtract = (aluOp == aluSub);
   assign arith    = (aluOp == aluAdd) || subtract;
   assign bEff     = subtract ? ~b : b;    // a - b = a + ~b + 1
   assign sum      = {1'b0, a} + {1'b0, bEff} + 33'(subtract);

   always_comb begin
      case (aluOp)
         aluAdd, aluSub: result = sum[31:0];
         aluAnd:         result = a & b;
         aluOrr:         result = a | b;
         aluEor:         result = a ^ b;
         aluPassB:       result = b;
         default:        result = '0;
      endcase
   end

   // Operands of equal sign giving a result of the other sign
   assign overflow = (a[31] == bEff[31]) && (sum[31] != a[31]);

   assign flags = '{
      n: result[31],
      z: (result == '0),
      c: arith && sum[32],    // Carry out, i.e. no borrow on sub
      v: arith && overflow
   };

endmodule

// ==== hw/regFile.sv ====
//------------------------------
// Register file, R0 to R14
// R15 reads as PC+8
//------------------------------
module regFile import armPkg::*; (
   input  logic     clk,
   input  logic     we,
   input  regAddr_t ra1,
   input  regAddr_t ra2,
   input  regAddr_t wa,
   input  word_t    wd,
   input  word_t    pcPlus8,
   output word_t    rd1,
   output word_t    rd2
);

   word_t regs [0:PcReg-1];

   // Falling-edge write lets decode see it in the same cycle
   always_ff @(negedge clk) begin
      if (we && wa != PcReg) regs[wa] <= wd;
   end

   assign rd1 = (ra1 == PcReg) ? pcPlus8 : regs[ra1];
   assign rd2 = (ra2 == PcReg) ? pcPlus8 : regs[ra2];

   // PC writes are outside the supported subset
   assert property (@(negedge clk) we |-> wa != PcReg);

endmodule

// ==== hw/hazardUnit.sv ====
//------------------------------
// Hazard unit
// Forwarding, load-use stall, branch flush
//------------------------------
module hazardUnit import armPkg::*; (
   input  regAddr_t    ra1D,
   input  regAddr_t    ra2D,
   input  regAddr_t    ra1E,
   input  regAddr_t    ra2E,
   input  regAddr_t    wa3E,
   input  regAddr_t    wa3M,
   input  regAddr_t    wa3W,
   input  logic        regWriteM,
   input  logic        regWriteW,
   input  logic        memToRegE,
   input  logic        branchTakenE,
   output forwardSel_e forwardAE,
   output forwardSel_e forwardBE,
   output logic        stallF,
   output logic        stallD,
   output logic        flushD,
   output logic        flushE
);

   logic loadUseD;

   // Memory stage holds the younger result, so it wins
   function automatic forwardSel_e forwardFor(
      input regAddr_t srcE,
      input regAddr_t dstM,
      input logic     writeM,
      input regAddr_t dstW,
      input logic     writeW
   );
      if (writeM && srcE == dstM)      return fromMemory;
      else if (writeW && srcE == dstW) return fromWriteback;
      else                             return fromReg;
   endfunction

   always_comb begin
      forwardAE = forwardFor(ra1E, wa3M, regWriteM, wa3W, regWriteW);
      forwardBE = forwardFor(ra2E, wa3M, regWriteM, wa3W, regWriteW);
   end

   // Load result is not ready until writeback
   assign loadUseD = memToRegE && (wa3E == ra1D || wa3E == ra2D);

   assign stallF = loadUseD;
   assign stallD = loadUseD;
   assign flushD = branchTakenE;
   assign flushE = loadUseD | branchTakenE;

endmodule

// ==== hw/controlUnit.sv ====
//------------------------------
// Control unit
// Decode, control pipeline, flags and condition check
//------------------------------
module controlUnit import armPkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  word_t      instrD,
   input  flags_t     aluFlagsE,
   input  logic       flushE,
   output logic [1:0] regSrcD,
   output immSrc_e    immSrcD,
   output logic       aluSrcE,
   output aluOp_e     aluOpE,
   output logic       branchTakenE,
   output logic       memToRegE,
   output logic       regWriteM,
   output logic       memWriteM,
   output logic       memToRegW,
   output logic       regWriteW
);

   opClass_e   opClassD;
   dpFunct_e   functD;
   logic       sBitD;
   logic       aluSrcD;
   aluOp_e     aluOpD;
   logic       memToRegD;
   logic       regWriteD;
   logic       memWriteD;
   logic       branchD;
   logic       noWriteD;
   logic [1:0] flagWriteD;     // [1] N and Z, [0] C and V
   logic       regWriteE;
   logic       memWriteE;
   logic       branchE;
   logic       noWriteE;
   logic [1:0] flagWriteE;
   condCode_e  condE;
   flags_t     flagsE;
   flags_t     flagsNextE;
   logic       condExE;
   logic       memToRegM;

   assign opClassD = opClass_e'(instrD[27:26]);
   assign functD   = dpFunct_e'(instrD[24:21]);
   assign sBitD    = instrD[20];

   always_comb begin
      regSrcD    = 2'b00;
      immSrcD    = imm8;
      aluSrcD    = 1'b0;
      aluOpD     = aluAdd;     // Address and target adds
      memToRegD  = 1'b0;
      regWriteD  = 1'b0;
      memWriteD  = 1'b0;
      branchD    = 1'b0;
      noWriteD   = 1'b0;
      flagWriteD = 2'b00;
      case (opClassD)
         opDataProc: begin
            aluSrcD       = instrD[25];     // I bit
            regWriteD     = 1'b1;
            flagWriteD[1] = sBitD;
            flagWriteD[0] = sBitD && (functD inside {dpAdd, dpSub, dpCmp});
            case (functD)
               dpAdd: aluOpD = aluAdd;
               dpSub: aluOpD = aluSub;
               dpAnd: aluOpD = aluAnd;
               dpOrr: aluOpD = aluOrr;
               dpEor: aluOpD = aluEor;
               dpMov: aluOpD = aluPassB;
               dpCmp: begin
                  aluOpD   = aluSub;
                  noWriteD = 1'b1;
               end
               default: begin              // Unsupported op leaves no trace
                  noWriteD   = 1'b1;
                  flagWriteD = 2'b00;
               end
            endcase
         end
         opMemory: begin
            regSrcD   = {~instrD[20], 1'b0};  // STR reads Rd on port 2
            immSrcD   = imm12;
            aluSrcD   = 1'b1;
            memToRegD = instrD[20];
            regWriteD = instrD[20];
            memWriteD = ~instrD[20];
         end
         opBranch: begin
            regSrcD = 2'b01;   // Base is R15
            immSrcD = branch24;
            aluSrcD = 1'b1;
            branchD = 1'b1;
         end
         default: regWriteD = 1'b0;
      endcase
   end

   // Execute controls, cleared into a bubble on flush
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         {regWriteE, memWriteE, memToRegE, branchE, noWriteE, flagWriteE} <= '0;
      end else if (flushE) begin
         {regWriteE, memWriteE, memToRegE, branchE, noWriteE, flagWriteE} <= '0;
      end else begin
         regWriteE  <= regWriteD;
         memWriteE  <= memWriteD;
         memToRegE  <= memToRegD;
         branchE    <= branchD;
         noWriteE   <= noWriteD;
         flagWriteE <= flagWriteD;
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         aluSrcE <= 1'b0;
         aluOpE  <= aluAdd;
         condE   <= condAl;
      end else begin
         aluSrcE <= aluSrcD;
         aluOpE  <= aluOpD;
         condE   <= condCode_e'(instrD[31:28]);
      end
   end

   always_comb begin
      case (condE)
         condEq:  condExE = flagsE.z;
         condNe:  condExE = ~flagsE.z;
         condCs:  condExE = flagsE.c;
         condCc:  condExE = ~flagsE.c;
         condMi:  condExE = flagsE.n;
         condPl:  condExE = ~flagsE.n;
         condVs:  condExE = flagsE.v;
         condVc:  condExE = ~flagsE.v;
         condHi:  condExE = flagsE.c & ~flagsE.z;
         condLs:  condExE = ~flagsE.c | flagsE.z;
         condGe:  condExE = (flagsE.n == flagsE.v);
         condLt:  condExE = (flagsE.n != flagsE.v);
         condGt:  condExE = ~flagsE.z & (flagsE.n == flagsE.v);
         condLe:  condExE = flagsE.z | (flagsE.n != flagsE.v);
         condAl:  condExE = 1'b1;
         default: condExE = 1'b0;   // 1111 is the bubble
      endcase
   end

   always_comb begin
      flagsNextE = flagsE;
      if (flagWriteE[1] && condExE) begin
         flagsNextE.n = aluFlagsE.n;
         flagsNextE.z = aluFlagsE.z;
      end
      if (flagWriteE[0] && condExE) begin
         flagsNextE.c = aluFlagsE.c;
         flagsNextE.v = aluFlagsE.v;
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) flagsE <= '0;
      else       flagsE <= flagsNextE;
   end

   assign branchTakenE = branchE & condExE;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         {regWriteM, memWriteM, memToRegM, regWriteW, memToRegW} <= '0;
      end else begin
         regWriteM <= regWriteE & condExE & ~noWriteE;   // CMP writes flags only
         memWriteM <= memWriteE & condExE;
         memToRegM <= memToRegE;
         regWriteW <= regWriteM;
         memToRegW <= memToRegM;
      end
   end

   // A store never reaches writeback as a register write
   assert property (@(posedge clk) disable iff (reset) memWriteM |=> !regWriteW);

   // Taken branch writes nothing, and the instruction behind it is squashed
   assert property (@(posedge clk) disable iff (reset)
      branchTakenE |=> !regWriteM && !memWriteM && !branchTakenE);

endmodule

// ==== hw/datapath.sv ====
//------------------------------
// Datapath
// PC, pipeline registers, forwarding and ALU
//------------------------------
module datapath import armPkg::*; #(
   parameter word_t ResetVector = '0
) (
   input  logic        clk,
   input  logic        reset,
   input  logic [1:0]  regSrcD,
   input  immSrc_e     immSrcD,
   input  logic        aluSrcE,
   input  aluOp_e      aluOpE,
   input  logic        branchTakenE,
   input  logic        memToRegW,
   input  logic        regWriteW,
   input  forwardSel_e forwardAE,
   input  forwardSel_e forwardBE,
   input  logic        stallF,
   input  logic        stallD,
   input  logic        flushD,
   output word_t       pcF,
   input  word_t       instrF,
   output word_t       instrD,
   output flags_t      aluFlagsE,
   output word_t       aluOutM,
   output word_t       writeDataM,
   input  word_t       readDataM,
   output regAddr_t    ra1D,
   output regAddr_t    ra2D,
   output regAddr_t    ra1E,
   output regAddr_t    ra2E,
   output regAddr_t    wa3E,
   output regAddr_t    wa3M,
   output regAddr_t    wa3W
);

   word_t pcPlus4F;
   word_t pcNextF;
   word_t pcPlus8D;
   word_t extImmD;
   word_t rd1D;
   word_t rd2D;
   word_t rd1E;
   word_t rd2E;
   word_t extImmE;
   word_t srcAE;
   word_t srcBE;
   word_t writeDataE;
   word_t aluResultE;
   word_t aluOutW;
   word_t readDataW;
   word_t resultW;

   function automatic word_t forwardMux(
      input forwardSel_e sel,
      input word_t       regVal,
      input word_t       wbVal,
      input word_t       memVal
   );
      case (sel)
         fromWriteback: return wbVal;
         fromMemory:    return memVal;
         default:       return regVal;
      endcase
   endfunction

   assign pcPlus4F = pcF + InstrBytes;
   assign pcNextF  = branchTakenE ? aluResultE : pcPlus4F;

   always_ff @(posedge clk or posedge reset) begin
      if (reset)        pcF <= ResetVector;
      else if (!stallF) pcF <= pcNextF;
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset)        instrD <= NopInstr;
      else if (flushD)  instrD <= NopInstr;
      else if (!stallD) instrD <= instrF;
   end

   assign pcPlus8D = pcPlus4F;   // Fetch runs one word ahead of decode
   assign ra1D     = regSrcD[0] ? PcReg : instrD[19:16];
   assign ra2D     = regSrcD[1] ? instrD[15:12] : instrD[3:0];

   always_comb begin
      case (immSrcD)
         imm8:     extImmD = {24'b0, instrD[7:0]};
         imm12:    extImmD = {20'b0, instrD[11:0]};
         branch24: extImmD = {{6{instrD[23]}}, instrD[23:0], 2'b00};
         default:  extImmD = '0;
      endcase
   end

   regFile regs (
      .clk, .we(regWriteW), .ra1(ra1D), .ra2(ra2D), .wa(wa3W),
      .wd(resultW), .pcPlus8(pcPlus8D), .rd1(rd1D), .rd2(rd2D)
   );

   always_ff @(posedge clk) begin
      rd1E    <= rd1D;
      rd2E    <= rd2D;
      extImmE <= extImmD;
      ra1E    <= ra1D;
      ra2E    <= ra2D;
      wa3E    <= instrD[15:12];   // Rd
   end

   assign srcAE      = forwardMux(forwardAE, rd1E, resultW, aluOutM);
   assign writeDataE = forwardMux(forwardBE, rd2E, resultW, aluOutM);
   assign srcBE      = aluSrcE ? extImmE : writeDataE;

   alu aluE (
      .a(srcAE), .b(srcBE), .aluOp(aluOpE), .result(aluResultE), .flags(aluFlagsE)
   );

   always_ff @(posedge clk) begin
      aluOutM    <= aluResultE;
      writeDataM <= writeDataE;
      wa3M       <= wa3E;
   end

   always_ff @(posedge clk) begin
      aluOutW   <= aluOutM;
      readDataW <= readDataM;
      wa3W      <= wa3M;
   end

   assign resultW = memToRegW ? readDataW : aluOutW;

endmodule

// ==== hw/armCore.sv ====
//------------------------------
// ARM pipelined core
// Control, datapath and hazard unit
//------------------------------
module armCore #(
   parameter armPkg::word_t ResetVector = '0
) (
   input  logic          clk,
   input  logic          reset,
   output armPkg::word_t pcF,
   input  armPkg::word_t instrF,
   output logic          memWriteM,
   output armPkg::word_t aluOutM,
   output armPkg::word_t writeDataM,
   input  armPkg::word_t readDataM
);

   armPkg::word_t       instrD;
   armPkg::flags_t      aluFlagsE;
   logic [1:0]          regSrcD;
   armPkg::immSrc_e     immSrcD;
   logic                aluSrcE;
   armPkg::aluOp_e      aluOpE;
   logic                branchTakenE;
   logic                memToRegE;
   logic                regWriteM;
   logic                memToRegW;
   logic                regWriteW;
   armPkg::forwardSel_e forwardAE;
   armPkg::forwardSel_e forwardBE;
   logic                stallF;
   logic                stallD;
   logic                flushD;
   logic                flushE;
   armPkg::regAddr_t    ra1D;
   armPkg::regAddr_t    ra2D;
   armPkg::regAddr_t    ra1E;
   armPkg::regAddr_t    ra2E;
   armPkg::regAddr_t    wa3E;
   armPkg::regAddr_t    wa3M;
   armPkg::regAddr_t    wa3W;

   controlUnit ctrl (
      .clk, .reset, .instrD, .aluFlagsE, .flushE, .regSrcD, .immSrcD,
      .aluSrcE, .aluOpE, .branchTakenE, .memToRegE, .regWriteM,
      .memWriteM, .memToRegW, .regWriteW
   );

   datapath #(.ResetVector(ResetVector)) dp (
      .clk, .reset, .regSrcD, .immSrcD, .aluSrcE, .aluOpE, .branchTakenE,
      .memToRegW, .regWriteW, .forwardAE, .forwardBE, .stallF, .stallD,
      .flushD, .pcF, .instrF, .instrD, .aluFlagsE, .aluOutM, .writeDataM,
      .readDataM, .ra1D, .ra2D, .ra1E, .ra2E, .wa3E, .wa3M, .wa3W
   );

   hazardUnit hazard (
      .ra1D, .ra2D, .ra1E, .ra2E, .wa3E, .wa3M, .wa3W, .regWriteM,
      .regWriteW, .memToRegE, .branchTakenE, .forwardAE, .forwardBE,
      .stallF, .stallD, .flushD, .flushE
   );

endmodule

// ==== verif/armCoreTb.sv ====
//------------------------------
// ARM core testbench
// Memory models, store monitor, directed tests
//------------------------------
module armCoreTb import armPkg::*; ();

   localparam word_t ExpectedResetPc = '0;              // armCore default
   localparam word_t Sentinel        = 32'h0000_03FC;   // Last store of every program
   localparam int    MaxCycles       = 200;

   logic  clk;
   logic  reset;
   word_t pcF;
   word_t instrF;
   logic  memWriteM;
   word_t aluOutM;
   word_t writeDataM;
   word_t readDataM;

   word_t      instrMem [0:255];
   word_t      dataMem  [0:255];
   logic       seedEn;          // Preset one data word while in reset
   logic [7:0] seedIdx;
   word_t      seedVal;

   word_t storeAddr [$];
   word_t storeData [$];
   word_t expAddr [$];
   word_t expData [$];
   word_t prog [$];
   int    storeBase;
   int    errors;
   int    timeouts;

   armCore UUT (
      .clk, .reset, .pcF, .instrF, .memWriteM, .aluOutM, .writeDataM, .readDataM
   );

   always #10 clk = ~clk;

   assign instrF    = instrMem[pcF[9:2]];
   assign readDataM = dataMem[aluOutM[9:2]];

   // Data memory reloads its fill pattern while reset is held
   always @(posedge clk) begin : dataMemModel
      int i;
      if (reset) begin
         for (i = 0; i < 256; i++) dataMem[i] <= 32'hDA00_0000 | word_t'(i << 2);
         if (seedEn) dataMem[seedIdx] <= seedVal;
      end else if (memWriteM) begin
         dataMem[aluOutM[9:2]] <= writeDataM;
      end
   end

   // Store monitor, sampled mid-cycle
   always @(negedge clk) begin
      if (!reset && memWriteM) begin
         storeAddr.push_back(aluOutM);
         storeData.push_back(writeDataM);
      end
   end

   // Instruction encoders
   function automatic word_t dpImm(input condCode_e cond, input dpFunct_e funct, input logic s,
                                   input regAddr_t rn, input regAddr_t rd, input logic [7:0] imm);
      return {cond, 2'b00, 1'b1, funct, s, rn, rd, 4'h0, imm};
   endfunction

   function automatic word_t dpReg(input condCode_e cond, input dpFunct_e funct, input logic s,
                                   input regAddr_t rn, input regAddr_t rd, input regAddr_t rm);
      return {cond, 2'b00, 1'b0, funct, s, rn, rd, 8'h00, rm};
   endfunction

   function automatic word_t memOp(input condCode_e cond, input logic load, input regAddr_t rn,
                                   input regAddr_t rd, input logic [11:0] off);
      return {cond, 2'b01, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, load, rn, rd, off};   // P=1 U=1
   endfunction

   // Target is relative to the branch address plus 8
   function automatic word_t branchTo(input condCode_e cond, input int from, input int to);
      return {cond, 4'b1010, 24'(to - from - 2)};
   endfunction

   function automatic flags_t subFlags(input word_t a, input word_t b);
      word_t  diff;
      flags_t f;
      diff = a - b;
      f.n  = diff[31];
      f.z  = (diff == '0);
      f.c  = (a >= b);     // No borrow
      f.v  = (a[31] != b[31]) && (diff[31] != a[31]);
      return f;
   endfunction

   function automatic logic condHolds(input condCode_e cond, input flags_t f);
      case (cond)
         condEq:  return f.z;
         condNe:  return !f.z;
         condCs:  return f.c;
         condCc:  return !f.c;
         condMi:  return f.n;
         condPl:  return !f.n;
         condHi:  return f.c && !f.z;
         condLs:  return !f.c || f.z;
         condGe:  return f.n == f.v;
         condLt:  return f.n != f.v;
         condGt:  return !f.z && (f.n == f.v);
         condLe:  return f.z || (f.n != f.v);
         condAl:  return 1'b1;
         default: return 1'b0;
      endcase
   endfunction

   function automatic logic sentinelStored();
      int i;
      for (i = storeBase; i < storeAddr.size(); i++) begin
         if (storeAddr[i] == Sentinel) return 1'b1;
      end
      return 1'b0;
   endfunction

   task automatic compareWord(input word_t got, input word_t exp, input string what);
      if (got !== exp) begin
         errors++;
         $display("FAILED at time %0t: %s, got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic compareCount(input int got, input int exp, input string what);
      if (got != exp) begin
         errors++;
         $display("FAILED at time %0t: %s, got %0d expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic compareBit(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         errors++;
         $display("FAILED at time %0t: %s, got %b expected %b", $time, what, got, exp);
      end
   endtask

   task automatic emit(input word_t instr);
      prog.push_back(instr);
   endtask

   task automatic expectStore(input word_t addr, input word_t data);
      expAddr.push_back(addr);
      expData.push_back(data);
   endtask

   task automatic startTest();
      prog.delete();
      expAddr.delete();
      expData.delete();
      emit(dpImm(condAl, dpMov, 1'b0, 4'd0, 4'd14, 8'd0));   // R14 is the zero base
   endtask

   task automatic emitSentinel();
      emit(memOp(condAl, 1'b0, 4'd14, 4'd14, Sentinel[11:0]));
      expectStore(Sentinel, '0);
   endtask

   task automatic fillInstrMem();
      int i;
      for (i = 0; i < 256; i++) instrMem[i] = {4'hF, 18'h0, 8'(i), 2'b00};   // Never-executed
   endtask

   task automatic loadProgram();
      int i;
      @(posedge clk);
      #2;
      reset = 1'b1;
      fillInstrMem();
      for (i = 0; i < prog.size(); i++) instrMem[i] = prog[i];
      storeBase = storeAddr.size();
   endtask

   task automatic releaseAndWait(input string name);
      int   cycles;
      logic found;
      repeat (3) @(posedge clk);
      #2;
      reset  = 1'b0;
      seedEn = 1'b0;
      cycles = 0;
      found  = 1'b0;
      while (!found && cycles < MaxCycles) begin
         @(posedge clk);
         cycles++;
         found = sentinelStored();
      end
      if (!found) begin
         timeouts++;
         $display("Timeout: %s did not reach its final store within %0d cycles", name, MaxCycles);
      end
   endtask

   task automatic checkStores(input string name);
      int i;
      int n;
      n = storeAddr.size() - storeBase;
      compareCount(n, expAddr.size(), {name, " store count"});
      for (i = 0; i < n && i < expAddr.size(); i++) begin
         compareWord(storeAddr[storeBase + i], expAddr[i], $sformatf("%s store %0d addr", name, i));
         compareWord(storeData[storeBase + i], expData[i], $sformatf("%s store %0d data", name, i));
      end
   endtask

   // STR R15,[R15,#0x100] at the reset vector, store due in cycle 3
   task automatic testReset();
      int n;
      prog.delete();
      emit(memOp(condAl, 1'b0, 4'd15, 4'd15, 12'h100));
      loadProgram();
      for (n = 0; n < 3; n++) begin
         @(negedge clk);
         compareWord(pcF, ExpectedResetPc, "pcF in reset");
         compareBit(memWriteM, 1'b0, "memWriteM in reset");
      end
      @(posedge clk);
      #2;
      reset = 1'b0;
      for (n = 0; n < 4; n++) begin
         @(negedge clk);
         compareWord(pcF, ExpectedResetPc + InstrBytes * word_t'(n), $sformatf("pcF cycle %0d", n));
         compareBit(memWriteM, n == 3, $sformatf("memWriteM cycle %0d", n));
      end
      compareWord(aluOutM, ExpectedResetPc + 32'd8 + 32'h100, "first store address");
      compareWord(writeDataM, ExpectedResetPc + 32'd8, "first store data");
   endtask

   task automatic testArith();
      logic [7:0] a;
      logic [7:0] b;
      logic [7:0] c;
      logic [7:0] d;
      word_t      r [1:8];
      int         k;
      a = 8'($urandom);
      b = 8'($urandom);
      c = 8'($urandom);
      d = 8'($urandom);
      r[1] = {24'h0, a};
      r[2] = r[1] + {24'h0, b};
      r[3] = r[2] - {24'h0, c};
      r[4] = r[3] & r[2];
      r[5] = r[4] | {24'h0, d};
      r[6] = r[5] ^ r[1];
      r[7] = r[6];
      r[8] = r[7] + r[3];
      startTest();
      emit(dpImm(condAl, dpMov, 1'b0, 4'd0, 4'd1, a));
      emit(dpImm(condAl, dpAdd, 1'b0, 4'd1, 4'd2, b));
      emit(dpImm(condAl, dpSub, 1'b0, 4'd2, 4'd3, c));
      emit(dpReg(condAl, dpAnd, 1'b0, 4'd3, 4'd4, 4'd2));
      emit(dpImm(condAl, dpOrr, 1'b0, 4'd4, 4'd5, d));
      emit(dpReg(condAl, dpEor, 1'b0, 4'd5, 4'd6, 4'd1));
      emit(dpReg(condAl, dpMov, 1'b0, 4'd0, 4'd7, 4'd6));
      emit(dpReg(condAl, dpAdd, 1'b0, 4'd7, 4'd8, 4'd3));
      emit(memOp(condAl, 1'b0, 4'd14, 4'd8, 12'h120));   // Store data straight from memory stage
      expectStore(32'h120, r[8]);
      for (k = 2; k <= 7; k++) begin
         emit(memOp(condAl, 1'b0, 4'd14, 4'(k), 12'(32'h100 + 4 * (k - 2))));
         expectStore(word_t'(32'h100 + 4 * (k - 2)), r[k]);
      end
      emitSentinel();
      loadProgram();
      releaseAndWait("arith");
      checkStores("arith");
   endtask

   task automatic testLoadUse();
      word_t      w;
      logic [7:0] k;
      w = $urandom;
      k = 8'($urandom);
      seedEn  = 1'b1;
      seedIdx = 8'h80;   // Byte address 0x200
      seedVal = w;
      startTest();
      emit(memOp(condAl, 1'b1, 4'd14, 4'd1, 12'h200));
      emit(memOp(condAl, 1'b0, 4'd14, 4'd1, 12'h204));
      emit(memOp(condAl, 1'b1, 4'd14, 4'd2, 12'h204));
      emit(dpImm(condAl, dpAdd, 1'b0, 4'd2, 4'd3, k));   // Needs the load result at once
      emit(memOp(condAl, 1'b0, 4'd14, 4'd3, 12'h208));
      expectStore(32'h204, w);
      expectStore(32'h208, w + {24'h0, k});
      emitSentinel();
      loadProgram();
      releaseAndWait("load-use");
      checkStores("load-use");
   endtask

   task automatic condStore(input condCode_e cond, input flags_t f, input logic [11:0] off);
      emit(memOp(cond, 1'b0, 4'd14, 4'd1, off));
      if (condHolds(cond, f)) expectStore({20'h0, off}, 32'd5);   // R1 holds 5
   endtask

   task automatic testConditions();
      flags_t f;
      startTest();
      emit(dpImm(condAl, dpMov, 1'b0, 4'd0, 4'd1, 8'd5));
      emit(dpImm(condAl, dpMov, 1'b0, 4'd0, 4'd2, 8'd5));
      emit(dpImm(condAl, dpMov, 1'b0, 4'd0, 4'd3, 8'd7));
      emit(dpReg(condAl, dpCmp, 1'b1, 4'd1, 4'd0, 4'd2));
      f = subFlags(32'd5, 32'd5);
      emit(dpImm(condAl, dpAdd, 1'b0, 4'd1, 4'd4, 8'd1));   // No S, flags stay
      condStore(condEq, f, 12'h100);
      condStore(condNe, f, 12'h104);
      condStore(condCs, f, 12'h108);
      condStore(condCc, f, 12'h10C);
      condStore(condHi, f, 12'h110);
      condStore(condLe, f, 12'h114);
      emit(dpReg(condAl, dpSub, 1'b1, 4'd1, 4'd5, 4'd3));
      f = subFlags(32'd5, 32'd7);
      condStore(condMi, f, 12'h118);
      condStore(condGe, f, 12'h11C);
      condStore(condLt, f, 12'h120);
      condStore(condCc, f, 12'h124);
      condStore(condEq, f, 12'h128);
      emit(dpImm(condAl, dpCmp, 1'b1, 4'd3, 4'd0, 8'd5));
      f = subFlags(32'd7, 32'd5);
      condStore(condHi, f, 12'h12C);
      condStore(condGe, f, 12'h130);
      condStore(condLe, f, 12'h134);
      emit(memOp(condAl, 1'b0, 4'd14, 4'd4, 12'h138));
      emit(memOp(condAl, 1'b0, 4'd14, 4'd5, 12'h13C));
      expectStore(32'h138, 32'd6);
      expectStore(32'h13C, 32'd5 - 32'd7);
      emitSentinel();
      loadProgram();
      releaseAndWait("conditions");
      checkStores("conditions");
   endtask

   task automatic testBranches();
      startTest();
      emit(dpImm(condAl, dpMov, 1'b0, 4'd0, 4'd1, 8'h11));
      emit(branchTo(condAl, prog.size(), 5));              // Skips two stores
      emit(memOp(condAl, 1'b0, 4'd14, 4'd1, 12'h100));
      emit(memOp(condAl, 1'b0, 4'd14, 4'd1, 12'h104));
      emit(memOp(condAl, 1'b0, 4'd14, 4'd1, 12'h108));
      expectStore(32'h108, 32'h11);
      emit(dpImm(condAl, dpCmp, 1'b1, 4'd1, 4'd0, 8'h11));  // Z set
      emit(branchTo(condNe, prog.size(), 10));             // Falls through
      emit(memOp(condAl, 1'b0, 4'd14, 4'd1, 12'h10C));
      emit(memOp(condAl, 1'b0, 4'd14, 4'd1, 12'h110));
      expectStore(32'h10C, 32'h11);
      expectStore(32'h110, 32'h11);
      emit(branchTo(condEq, prog.size(), 13));
      emit(memOp(condAl, 1'b0, 4'd14, 4'd1, 12'h114));
      emit(memOp(condAl, 1'b0, 4'd14, 4'd1, 12'h118));
      emit(memOp(condAl, 1'b0, 4'd14, 4'd1, 12'h11C));
      expectStore(32'h11C, 32'h11);
      emitSentinel();
      loadProgram();
      releaseAndWait("branches");
      checkStores("branches");
   endtask

   task automatic testPcRead();
      startTest();
      expectStore(32'h100, ExpectedResetPc + word_t'(prog.size() * 4 + 8) + 32'h10);
      emit(dpImm(condAl, dpAdd, 1'b0, 4'd15, 4'd1, 8'h10));
      emit(memOp(condAl, 1'b0, 4'd14, 4'd1, 12'h100));
      expectStore(32'h104, ExpectedResetPc + word_t'(prog.size() * 4 + 8) + 32'h24);
      emit(dpImm(condAl, dpAdd, 1'b0, 4'd15, 4'd2, 8'h24));
      emit(memOp(condAl, 1'b0, 4'd14, 4'd2, 12'h104));
      emitSentinel();
      loadProgram();
      releaseAndWait("R15 read");
      checkStores("R15 read");
   endtask

   initial begin
      clk       = 1'b0;
      reset     = 1'b1;
      seedEn    = 1'b0;
      seedIdx   = '0;
      seedVal   = '0;
      errors    = 0;
      timeouts  = 0;
      storeBase = 0;
      fillInstrMem();
      void'($urandom(32'h854d23fb));
      testReset();
      testArith();
      testLoadUse();
      testConditions();
      testBranches();
      testPcRead();
      $display("Errors: %0d, timeouts: %0d", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

// ==== files.f ====
hw/armPkg.sv
hw/alu.sv
hw/regFile.sv
hw/hazardUnit.sv
hw/controlUnit.sv
hw/datapath.sv
hw/armCore.sv
verif/armCoreTb.sv

// ==== Makefile ====
# Verilator lint, simulation and clean for the ARM core testbench

VERILATOR ?= verilator
TOP       ?= armCoreTb
FILELIST  ?= files.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJDIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)

sim: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "TESTS PASSED" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)
